/* Bender.yml */
package:
  name: multicycle_control

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_ctrl_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/step_sequencer.sv
      - rtl/control_encoder.sv
      - rtl/multicycle_control.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/multicycle_control_assertions.sv
      - testbench/multicycle_control_tb.sv

/* rtl/control_encoder.sv */
`timescale 1ns/10ps

module control_encoder import mips_ctrl_pkg::*; (
	input  step_t        i_step,
	input  instr_class_t i_instr_class,
	input  alu_op_t      i_alu_op,
	input  logic         i_shift,
	output alu_op_t      o_alu_op,
	output logic         o_alu_src,
	output logic         o_shift,
	output logic         o_i_or_d,
	output logic         o_reg_dst,
	output logic         o_reg_write,
	output logic         o_mem_to_reg,
	output logic         o_mem_write
);

	logic instr_active;

	// steps that carry the decoded instruction
	assign instr_active = (i_step == EXECUTE) || (i_step == MEMORY) || (i_step == WRITEBACK);

	always_comb begin
		// fetch uses ADD on register source for pc increment
		o_alu_op = ADD;
		o_alu_src = 1'b0;
		o_shift = 1'b0;
		o_i_or_d = 1'b0;
		o_reg_dst = 1'b0;
		o_reg_write = 1'b0;
		o_mem_to_reg = 1'b0;
		o_mem_write = 1'b0;

		if (instr_active) begin
			o_alu_op = i_alu_op;
			o_shift = i_shift;
			// immediate operand for everything but R-type
			o_alu_src = (i_instr_class != ALU_R);
		end

		case (i_step)
			MEMORY: begin
				o_i_or_d = 1'b1;
				o_mem_write = (i_instr_class == STORE);
			end
			WRITEBACK: begin
				o_reg_write = 1'b1;
				o_reg_dst = (i_instr_class == ALU_R);
				o_mem_to_reg = (i_instr_class == LOAD);
			end
			default: begin
				o_i_or_d = 1'b0;
			end
		endcase
	end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps

`include "mips_ctrl_consts.svh"

module instr_decoder import mips_ctrl_pkg::*; (
	input  instr_word_t  i_instr,
	output instr_class_t o_instr_class,
	output alu_op_t      o_alu_op,
	output logic         o_shift
);

	always_comb begin
		o_instr_class = ILLEGAL;
		o_alu_op = ADD;
		o_shift = 1'b0;

		case (i_instr.i.opcode)
			`OP_RTYPE: begin
				o_instr_class = ALU_R;
				case (i_instr.r.funct)
					`FN_ADD: o_alu_op = ADD;
					`FN_SUB: o_alu_op = SUB;
					`FN_AND: o_alu_op = AND;
					`FN_OR:  o_alu_op = OR;
					`FN_XOR: o_alu_op = XOR;
					`FN_SLL: begin
						o_alu_op = SLL;
						o_shift = 1'b1;
					end
					`FN_SRL: begin
						o_alu_op = SRL;
						o_shift = 1'b1;
					end
					// unknown funct
					default: o_instr_class = ILLEGAL;
				endcase
			end
			`OP_ADDI: begin
				o_instr_class = ALU_I;
				o_alu_op = ADD;
			end
			`OP_ANDI: begin
				o_instr_class = ALU_I;
				o_alu_op = AND;
			end
			`OP_ORI: begin
				o_instr_class = ALU_I;
				o_alu_op = OR;
			end
			`OP_XORI: begin
				o_instr_class = ALU_I;
				o_alu_op = XOR;
			end
			`OP_LUI: begin
				o_instr_class = ALU_I;
				o_alu_op = LUI;
			end
			// address is base plus offset
			`OP_LW: begin
				o_instr_class = LOAD;
				o_alu_op = ADD;
			end
			`OP_SW: begin
				o_instr_class = STORE;
				o_alu_op = ADD;
			end
			default: begin
				o_instr_class = ILLEGAL;
			end
		endcase
	end

endmodule

/* rtl/mips_ctrl_consts.svh */
`ifndef MIPS_CTRL_CONSTS_SVH
`define MIPS_CTRL_CONSTS_SVH

// instruction field widths
`define INSTR_W     32
`define OPCODE_W    6
`define FUNCT_W     6
`define REG_ADDR_W  5
`define SHAMT_W     5
`define IMM_W       16

// primary opcodes
`define OP_RTYPE    6'b000000
`define OP_ADDI     6'b001000
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// memory access
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// funct codes under OP_RTYPE
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110

// shifts take the amount from shamt
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010

`endif

/* rtl/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	`include "mips_ctrl_consts.svh"

	// same 32-bit word seen as R-format or I-format
	typedef union packed {
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [`REG_ADDR_W-1:0] rd;
			logic [`SHAMT_W-1:0]    shamt;
			logic [`FUNCT_W-1:0]    funct;
		} r;
		struct packed {
			logic [`OPCODE_W-1:0]   opcode;
			logic [`REG_ADDR_W-1:0] rs;
			logic [`REG_ADDR_W-1:0] rt;
			logic [`IMM_W-1:0]      imm;
		} i;
	} instr_word_t;

	typedef enum logic [2:0] {
		ALU_R,
		ALU_I,
		LOAD,
		STORE,
		ILLEGAL
	} instr_class_t;

	// datapath ALU codes
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		SLL = 3'd5,
		SRL = 3'd6,
		LUI = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK
	} step_t;

endpackage

/* rtl/multicycle_control.sv */
`timescale 1ns/10ps

module multicycle_control import mips_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  instr_word_t i_instr,
	input  logic        i_mem_ack,
	output logic        o_mem_req,
	output logic        o_ir_write,
	output logic        o_pc_write,
	output alu_op_t     o_alu_op,
	output logic        o_alu_src,
	output logic        o_shift,
	output logic        o_i_or_d,
	output logic        o_reg_dst,
	output logic        o_reg_write,
	output logic        o_mem_to_reg,
	output logic        o_mem_write,
	output logic        o_illegal
);

	instr_class_t instr_class;
	alu_op_t      dec_alu_op;
	logic         dec_shift;
	step_t        step;

	instr_decoder instr_decoder_i (
		.i_instr       (i_instr),
		.o_instr_class (instr_class),
		.o_alu_op      (dec_alu_op),
		.o_shift       (dec_shift)
	);

	step_sequencer step_sequencer_i (
		.clk           (clk),
		.reset         (reset),
		.i_mem_ack     (i_mem_ack),
		.i_instr_class (instr_class),
		.o_step        (step),
		.o_mem_req     (o_mem_req),
		.o_ir_write    (o_ir_write),
		.o_pc_write    (o_pc_write),
		.o_illegal     (o_illegal)
	);

	control_encoder control_encoder_i (
		.i_step        (step),
		.i_instr_class (instr_class),
		.i_alu_op      (dec_alu_op),
		.i_shift       (dec_shift),
		.o_alu_op      (o_alu_op),
		.o_alu_src     (o_alu_src),
		.o_shift       (o_shift),
		.o_i_or_d      (o_i_or_d),
		.o_reg_dst     (o_reg_dst),
		.o_reg_write   (o_reg_write),
		.o_mem_to_reg  (o_mem_to_reg),
		.o_mem_write   (o_mem_write)
	);

endmodule

/* rtl/step_sequencer.sv */
`timescale 1ns/10ps

module step_sequencer import mips_ctrl_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         i_mem_ack,
	input  instr_class_t i_instr_class,
	output step_t        o_step,
	output logic         o_mem_req,
	output logic         o_ir_write,
	output logic         o_pc_write,
	output logic         o_illegal
);

	step_t step_q;
	step_t step_d;
	logic  req_q;
	logic  req_d;
	logic  access_step;
	logic  mem_done;

	// only fetch and memory steps talk to memory
	assign access_step = (step_q == FETCH) || (step_q == MEMORY);

	// transfer ends on the cycle ack is sampled with req up
	assign mem_done = req_q && i_mem_ack;

	// new request only once ack from the last transfer is gone
	always_comb begin
		if (mem_done) begin
			req_d = 1'b0;
		end else if (access_step && !i_mem_ack) begin
			req_d = 1'b1;
		end else begin
			req_d = req_q;
		end
	end

	always_comb begin
		step_d = step_q;
		case (step_q)
			FETCH: begin
				if (mem_done) begin
					step_d = DECODE;
				end
			end
			DECODE: begin
				if (i_instr_class == ILLEGAL) begin
					step_d = FETCH;
				end else begin
					step_d = EXECUTE;
				end
			end
			EXECUTE: begin
				if (i_instr_class == LOAD || i_instr_class == STORE) begin
					step_d = MEMORY;
				end else begin
					step_d = WRITEBACK;
				end
			end
			MEMORY: begin
				if (mem_done) begin
					// stores are done once memory accepts the write
					step_d = (i_instr_class == LOAD) ? WRITEBACK : FETCH;
				end
			end
			WRITEBACK: begin
				step_d = FETCH;
			end
			default: begin
				step_d = FETCH;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			step_q <= FETCH;
			req_q <= 1'b0;
		end else begin
			step_q <= step_d;
			req_q <= req_d;
		end
	end

	assign o_step = step_q;
	assign o_mem_req = req_q;

	// IR and PC both load when the fetch completes
	assign o_ir_write = (step_q == FETCH) && mem_done;
	assign o_pc_write = o_ir_write;

	assign o_illegal = (step_q == DECODE) && (i_instr_class == ILLEGAL);

endmodule

/* testbench/multicycle_control_assertions.sv */
`timescale 1ns/10ps

module multicycle_control_assertions (
	input logic clk,
	input logic reset,
	input logic i_mem_ack,
	input logic i_mem_req,
	input logic i_ir_write,
	input logic i_i_or_d,
	input logic i_reg_write,
	input logic i_mem_write
);

	int fail_count = 0;

	// request stays up until ack is sampled
	assert property (@(posedge clk) disable iff (reset)
		i_mem_req && !i_mem_ack |=> i_mem_req)
	else begin
		fail_count++;
		$error("memory request dropped before acknowledge");
	end

	// IR loads only from a completed instruction fetch, never a data access
	assert property (@(posedge clk) disable iff (reset)
		i_ir_write |-> i_mem_req && i_mem_ack && !i_i_or_d)
	else begin
		fail_count++;
		$error("instruction register write without a completed fetch");
	end

	assert property (@(posedge clk) disable iff (reset)
		!(i_reg_write && i_mem_write))
	else begin
		fail_count++;
		$error("register write and memory write active together");
	end

	// four-phase return to zero before the next request
	assert property (@(posedge clk) disable iff (reset)
		!i_mem_req && i_mem_ack |=> !i_mem_req)
	else begin
		fail_count++;
		$error("memory request raised while acknowledge still high");
	end

endmodule

bind multicycle_control multicycle_control_assertions multicycle_control_assertions_i (
	.clk         (clk),
	.reset       (reset),
	.i_mem_ack   (i_mem_ack),
	.i_mem_req   (o_mem_req),
	.i_ir_write  (o_ir_write),
	.i_i_or_d    (o_i_or_d),
	.i_reg_write (o_reg_write),
	.i_mem_write (o_mem_write)
);

/* testbench/multicycle_control_tb.sv */
`timescale 1ns/10ps

`include "mips_ctrl_consts.svh"

module multicycle_control_tb import mips_ctrl_pkg::*; ();

	localparam int WAIT_LIMIT = 40;

	logic        clk;
	logic        reset;
	instr_word_t i_instr;
	logic        i_mem_ack;
	logic        o_mem_req, o_ir_write, o_pc_write;
	alu_op_t     o_alu_op;
	logic        o_alu_src, o_shift, o_i_or_d;
	logic        o_reg_dst, o_reg_write, o_mem_to_reg, o_mem_write;
	logic        o_illegal;

	// word the memory returns on the next fetch
	instr_word_t next_instr;
	integer      seed;
	int          value_errors;
	int          timeouts;

	multicycle_control multicycle_control_i (.*);

	always #4 clk = ~clk;

	// ack after 0 to 3 cycles, held until req drops
	task automatic respond_memory();
		int wait_left;
		bit pending;
		pending = 1'b0;
		wait_left = 0;
		forever begin
			@(negedge clk);
			if (i_mem_ack) begin
				if (!o_mem_req) i_mem_ack = 1'b0;
			end else if (o_mem_req) begin
				if (!pending) begin
					pending = 1'b1;
					wait_left = $unsigned($random(seed)) % 4;
				end
				if (wait_left == 0) begin
					pending = 1'b0;
					i_mem_ack = 1'b1;
					// instruction word comes with the fetch response
					if (!o_i_or_d) i_instr = next_instr;
				end else begin
					wait_left--;
				end
			end
		end
	endtask

	task automatic report_mismatch(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
		value_errors++;
	endtask

	// cycle count until the event, -1 on timeout
	task automatic wait_event(input string test_name, input string what, output int n);
		bit hit;
		hit = 1'b0;
		n = 0;
		while (!hit && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
			if (what == "o_ir_write")
				hit = (o_ir_write === 1'b1);
			else
				hit = (o_reg_write === 1'b1);
		end
		if (!hit) begin
			$display("%s: %s did not arrive within %0d cycles", test_name, what, WAIT_LIMIT);
			timeouts++;
			n = -1;
		end
	endtask

	// counts write enables up to the next completed fetch
	task automatic watch_until_fetch(input string test_name, output int reg_writes,
		output int mem_writes, output int loaded);
		bit fetched;
		int n;
		fetched = 1'b0;
		n = 0;
		reg_writes = 0;
		mem_writes = 0;
		loaded = 0;
		while (!fetched && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
			fetched = (o_ir_write === 1'b1);
			reg_writes += (o_reg_write === 1'b1);
			mem_writes += (o_mem_write === 1'b1);
			loaded += (o_reg_write === 1'b1 && o_mem_to_reg === 1'b1);
		end
		if (!fetched) begin
			$display("%s: next fetch did not complete within %0d cycles", test_name, WAIT_LIMIT);
			timeouts++;
		end
	endtask

	function automatic instr_word_t make_r(input logic [`FUNCT_W-1:0] funct);
		instr_word_t w;
		w.r = '{`OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd4, funct};
		return w;
	endfunction

	function automatic instr_word_t make_i(input logic [`OPCODE_W-1:0] opcode,
		input logic [`IMM_W-1:0] imm);
		instr_word_t w;
		w.i = '{opcode, 5'd6, 5'd7, imm};
		return w;
	endfunction

	task automatic check_idle(input string test_name);
		logic [5:0] flags;
		flags = {o_mem_req, o_ir_write, o_pc_write, o_reg_write, o_mem_write, o_illegal};
		if (flags !== 6'b0) report_mismatch(test_name, "req/ir/pc/reg/mem/illegal", 0, flags);
	endtask

	task automatic run_reset_test();
		@(posedge clk);
		repeat (4) begin
			@(posedge clk);
			check_idle("reset");
		end
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		check_idle("after reset");
	endtask

	task automatic run_alu_test(input string test_name, input instr_word_t word,
		input alu_op_t exp_op, input logic exp_shift, input logic rtype);
		int n;
		next_instr = word;
		wait_event(test_name, "o_ir_write", n);
		if (n < 0) return;
		if (o_pc_write !== 1'b1) report_mismatch(test_name, "o_pc_write", 1, o_pc_write);
		wait_event(test_name, "o_reg_write", n);
		if (n < 0) return;
		if (n != 3) report_mismatch(test_name, "cycles to o_reg_write", 3, n);
		if (o_reg_dst !== rtype) report_mismatch(test_name, "o_reg_dst", rtype, o_reg_dst);
		if (o_alu_src !== !rtype) report_mismatch(test_name, "o_alu_src", !rtype, o_alu_src);
		if (o_alu_op !== exp_op) report_mismatch(test_name, "o_alu_op", exp_op, o_alu_op);
		if (o_shift !== exp_shift) report_mismatch(test_name, "o_shift", exp_shift, o_shift);
	endtask

	task automatic run_mem_test(input string test_name, input instr_word_t word,
		input logic store);
		int  n;
		int  exp_writes;
		int  reg_writes;
		int  mem_writes;
		int  loaded;
		bit  done;
		exp_writes = store ? 0 : 1;
		next_instr = word;
		wait_event(test_name, "o_ir_write", n);
		if (n < 0) return;
		done = 1'b0;
		n = 0;
		// data transfer ends on the cycle ack is sampled
		while (!done && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
			if (o_mem_req === 1'b1) begin
				if (o_i_or_d !== 1'b1) report_mismatch(test_name, "o_i_or_d", 1, o_i_or_d);
				if (o_mem_write !== store) begin
					report_mismatch(test_name, "o_mem_write", store, o_mem_write);
				end
				done = (i_mem_ack === 1'b1);
			end
		end
		if (!done) begin
			$display("%s: data access did not complete within %0d cycles", test_name, WAIT_LIMIT);
			timeouts++;
			return;
		end
		watch_until_fetch(test_name, reg_writes, mem_writes, loaded);
		if (reg_writes != exp_writes) begin
			report_mismatch(test_name, "o_reg_write count", exp_writes, reg_writes);
		end
		if (loaded != exp_writes) report_mismatch(test_name, "loaded writes", exp_writes, loaded);
		if (mem_writes != 0) report_mismatch(test_name, "late o_mem_write", 0, mem_writes);
	endtask

	task automatic run_illegal_test(input string test_name, input instr_word_t word);
		int n;
		int reg_writes;
		int mem_writes;
		int loaded;
		next_instr = word;
		wait_event(test_name, "o_ir_write", n);
		if (n < 0) return;
		@(posedge clk);
		if (o_illegal !== 1'b1) report_mismatch(test_name, "o_illegal", 1, o_illegal);
		watch_until_fetch(test_name, reg_writes, mem_writes, loaded);
		if (reg_writes != 0) report_mismatch(test_name, "o_reg_write count", 0, reg_writes);
		if (mem_writes != 0) report_mismatch(test_name, "o_mem_write count", 0, mem_writes);
	endtask

	initial begin
		int assert_fails;
		clk = 1'b0;
		reset = 1'b1;
		i_mem_ack = 1'b0;
		i_instr = '0;
		next_instr = '0;
		seed = 78265;
		value_errors = 0;
		timeouts = 0;
		fork
			respond_memory();
		join_none

		run_reset_test();
		run_alu_test("add", make_r(`FN_ADD), ADD, 1'b0, 1'b1);
		run_alu_test("sub", make_r(`FN_SUB), SUB, 1'b0, 1'b1);
		run_alu_test("and", make_r(`FN_AND), AND, 1'b0, 1'b1);
		run_alu_test("or", make_r(`FN_OR), OR, 1'b0, 1'b1);
		run_alu_test("xor", make_r(`FN_XOR), XOR, 1'b0, 1'b1);
		run_alu_test("sll", make_r(`FN_SLL), SLL, 1'b1, 1'b1);
		run_alu_test("srl", make_r(`FN_SRL), SRL, 1'b1, 1'b1);
		run_alu_test("addi", make_i(`OP_ADDI, 16'h0040), ADD, 1'b0, 1'b0);
		run_alu_test("andi", make_i(`OP_ANDI, 16'h00ff), AND, 1'b0, 1'b0);
		run_alu_test("ori", make_i(`OP_ORI, 16'h0f0f), OR, 1'b0, 1'b0);
		run_alu_test("xori", make_i(`OP_XORI, 16'haaaa), XOR, 1'b0, 1'b0);
		run_alu_test("lui", make_i(`OP_LUI, 16'h1234), LUI, 1'b0, 1'b0);
		run_mem_test("lw", make_i(`OP_LW, 16'h0010), 1'b0);
		run_mem_test("lw negative offset", make_i(`OP_LW, 16'hfffc), 1'b0);
		run_mem_test("sw", make_i(`OP_SW, 16'h0020), 1'b1);
		run_mem_test("sw negative offset", make_i(`OP_SW, 16'hfff8), 1'b1);
		run_illegal_test("unknown opcode", make_i(6'b111111, 16'h1234));
		run_illegal_test("unknown funct", make_r(6'b101010));

		assert_fails = multicycle_control_i.multicycle_control_assertions_i.fail_count;
		$display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
			value_errors, timeouts, assert_fails);
		if (value_errors == 0 && timeouts == 0 && assert_fails == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/mips_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/step_sequencer.sv
rtl/control_encoder.sv
rtl/multicycle_control.sv
testbench/multicycle_control_assertions.sv
testbench/multicycle_control_tb.sv
